/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := multicycle_cpu_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
hdl/rv_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/imm_gen.sv
hdl/unified_mem.sv
hdl/control_unit.sv
hdl/multicycle_cpu.sv
test/multicycle_cpu_tb.sv

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  rv_pkg::alu_ctrl_t       alu_ctrl,
	input  logic [2:0]              funct3,
	input  logic                    funct7_5,
	input  logic [rv_pkg::xlen-1:0] a,
	input  logic [rv_pkg::xlen-1:0] b,
	output logic [rv_pkg::xlen-1:0] result,
	output logic                    bcond
);

	logic [4:0] shamt;
	logic lt_s;
	logic lt_u;

	assign shamt = b[4:0];
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	always_comb begin
		case (alu_ctrl)
			rv_pkg::alu_add: result = a + b;
			rv_pkg::alu_sub: result = a - b;
			rv_pkg::alu_func: begin
				case (funct3)
					3'b000: result = funct7_5 ? a - b : a + b;
					3'b001: result = a << shamt;
					3'b010: result = {{(rv_pkg::xlen-1){1'b0}}, lt_s};
					3'b011: result = {{(rv_pkg::xlen-1){1'b0}}, lt_u};
					3'b100: result = a ^ b;
					3'b101: result = funct7_5 ? $unsigned($signed(a) >>> shamt) : a >> shamt;
					3'b110: result = a | b;
					default: result = a & b;
				endcase
			end
			default: result = '0;
		endcase
	end

	// branch condition from funct3 is sampled only in ex1 of a branch
	always_comb begin
		case (funct3)
			3'b000: bcond = (a == b);  // beq
			3'b001: bcond = (a != b);
			3'b100: bcond = lt_s;      // blt
			3'b101: bcond = ~lt_s;
			3'b110: bcond = lt_u;      // bltu
			3'b111: bcond = ~lt_u;
			default: bcond = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [rv_pkg::opcode_w-1:0] opcode,
	input  logic                        alu_bcond,
	output logic                        pc_write,
	output logic                        pc_write_not_cond,
	output logic                        iord,
	output logic                        mem_read,
	output logic                        mem_write,
	output logic                        ir_write,
	output logic                        reg_write,
	output logic                        mem_to_reg,
	output rv_pkg::pc_src_t             pc_source,
	output rv_pkg::alu_ctrl_t           alu_ctrl,
	output rv_pkg::alu_src_a_t          alu_src_a,
	output rv_pkg::alu_src_b_t          alu_src_b,
	output logic                        halted
);

	rv_pkg::ctrl_state_t state;
	rv_pkg::ctrl_state_t state_next;
	rv_pkg::opcode_t op;

	logic is_rtype;
	logic is_itype;
	logic is_load;
	logic is_store;
	logic is_branch;
	logic is_jal;
	logic is_jalr;
	logic is_ecall;
	logic is_exec;  // classes that go through ex1

	assign op = rv_pkg::opcode_t'(opcode);

	assign is_rtype  = (op == rv_pkg::op_arith);
	assign is_itype  = (op == rv_pkg::op_arith_imm);
	assign is_load   = (op == rv_pkg::op_load);
	assign is_store  = (op == rv_pkg::op_store);
	assign is_branch = (op == rv_pkg::op_branch);
	assign is_jal    = (op == rv_pkg::op_jal);
	assign is_jalr   = (op == rv_pkg::op_jalr);
	assign is_ecall  = (op == rv_pkg::op_ecall);
	assign is_exec   = is_rtype | is_itype | is_load | is_store | is_branch;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rv_pkg::st_if;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		case (state)
			rv_pkg::st_if: state_next = rv_pkg::st_id;
			rv_pkg::st_id: begin
				if (is_jal || is_jalr) begin
					state_next = rv_pkg::st_wb;  // link and jump straight away
				end else if (is_ecall || !is_exec) begin
					state_next = rv_pkg::st_halt;  // unsupported opcodes stop as well
				end else begin
					state_next = rv_pkg::st_ex1;
				end
			end
			rv_pkg::st_ex1: begin
				if (is_load || is_store) begin
					state_next = rv_pkg::st_mem1;
				end else if (is_branch) begin
					state_next = alu_bcond ? rv_pkg::st_ex2 : rv_pkg::st_if;
				end else begin
					state_next = rv_pkg::st_wb;
				end
			end
			rv_pkg::st_ex2:  state_next = rv_pkg::st_if;
			rv_pkg::st_mem1: state_next = is_load ? rv_pkg::st_wb : rv_pkg::st_if;
			rv_pkg::st_wb:   state_next = rv_pkg::st_if;
			rv_pkg::st_halt: state_next = rv_pkg::st_halt;
			default:         state_next = rv_pkg::st_if;
		endcase
	end

	always_comb begin
		pc_write = 1'b0;
		pc_write_not_cond = 1'b0;
		iord = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		ir_write = 1'b0;
		reg_write = 1'b0;
		mem_to_reg = 1'b0;
		halted = 1'b0;
		pc_source = rv_pkg::pc_alu_result;
		// idle alu setting is pc+4
		alu_ctrl = rv_pkg::alu_add;
		alu_src_a = rv_pkg::src_a_pc;
		alu_src_b = rv_pkg::src_b_four;

		case (state)
			rv_pkg::st_if: begin
				mem_read = 1'b1;  // ir <- mem[pc]
				ir_write = 1'b1;
			end
			rv_pkg::st_id: begin
				// a, b latch from the register file; aluout <- pc+4
				halted = is_ecall | ~(is_exec | is_jal | is_jalr);
			end
			rv_pkg::st_ex1: begin
				alu_src_a = rv_pkg::src_a_reg;
				if (is_rtype) begin
					alu_src_b = rv_pkg::src_b_reg;
					alu_ctrl = rv_pkg::alu_func;
				end else if (is_itype) begin
					alu_src_b = rv_pkg::src_b_imm;
					alu_ctrl = rv_pkg::alu_func;
				end else if (is_branch) begin
					alu_src_b = rv_pkg::src_b_reg;
					alu_ctrl = rv_pkg::alu_sub;
					pc_write_not_cond = 1'b1;  // pc <- aluout (pc+4) when not taken
					pc_source = rv_pkg::pc_alu_out;
				end else begin
					alu_src_b = rv_pkg::src_b_imm;  // load/store address
				end
			end
			rv_pkg::st_ex2: begin
				alu_src_b = rv_pkg::src_b_imm;  // branch target pc+imm
				pc_write = 1'b1;
			end
			rv_pkg::st_mem1: begin
				iord = 1'b1;
				mem_read = is_load;
				mem_write = is_store;
				pc_write = is_store;  // store retires here
			end
			rv_pkg::st_wb: begin
				reg_write = 1'b1;
				pc_write = 1'b1;
				mem_to_reg = is_load;
				if (is_jal) begin
					alu_src_b = rv_pkg::src_b_imm;
				end else if (is_jalr) begin
					alu_src_a = rv_pkg::src_a_reg;
					alu_src_b = rv_pkg::src_b_imm;
				end
			end
			rv_pkg::st_halt: halted = 1'b1;
			default: ;
		endcase
	end

	// one memory port, so a cycle either reads or writes
	a_mem_rw_excl: assert property (@(posedge clk) disable iff (reset)
		!(mem_read && mem_write))
		else $error("control_unit: mem_read and mem_write high together");

endmodule

`default_nettype wire

/* hdl/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
	input  logic [rv_pkg::xlen-1:0] inst,
	output logic [rv_pkg::xlen-1:0] imm
);

	rv_pkg::opcode_t op;

	assign op = rv_pkg::opcode_t'(inst[rv_pkg::opcode_w-1:0]);

	always_comb begin
		case (op)
			// i-type, also used by loads and jalr
			rv_pkg::op_arith_imm,
			rv_pkg::op_load,
			rv_pkg::op_jalr: imm = {{20{inst[31]}}, inst[31:20]};
			rv_pkg::op_store: begin
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			end
			rv_pkg::op_branch: begin
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			rv_pkg::op_jal: begin
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: imm = '0;  // r-type, ecall
		endcase
	end

endmodule

`default_nettype wire

/* hdl/multicycle_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module multicycle_cpu #(
	parameter int MEM_WORDS = 256
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         load_en,
	input  logic [$clog2(MEM_WORDS)-1:0] load_addr,  // word address
	input  logic [rv_pkg::xlen-1:0]      load_data,
	output logic                         halted,
	output logic                         store_valid,
	output logic [rv_pkg::xlen-1:0]      store_addr,
	output logic [rv_pkg::xlen-1:0]      store_data
);

	localparam int load_aw = $clog2(MEM_WORDS);

	logic [rv_pkg::xlen-1:0] pc;
	logic [rv_pkg::xlen-1:0] ir;
	logic [rv_pkg::xlen-1:0] mdr;
	logic [rv_pkg::xlen-1:0] a_reg;
	logic [rv_pkg::xlen-1:0] b_reg;
	logic [rv_pkg::xlen-1:0] alu_out;

	logic pc_write;
	logic pc_write_not_cond;
	logic iord;
	logic mem_read;
	logic mem_write;
	logic ir_write;
	logic reg_write;
	logic mem_to_reg;
	rv_pkg::pc_src_t pc_source;
	rv_pkg::alu_ctrl_t alu_ctrl;
	rv_pkg::alu_src_a_t alu_src_a;
	rv_pkg::alu_src_b_t alu_src_b;

	logic [rv_pkg::xlen-1:0] rdata1;
	logic [rv_pkg::xlen-1:0] rdata2;
	logic [rv_pkg::xlen-1:0] imm;
	logic [rv_pkg::xlen-1:0] alu_a;
	logic [rv_pkg::xlen-1:0] alu_b;
	logic [rv_pkg::xlen-1:0] alu_result;
	logic alu_bcond;
	logic funct7_5;
	logic [rv_pkg::xlen-1:0] wb_data;
	logic [rv_pkg::xlen-1:0] pc_next;
	logic pc_en;
	logic [rv_pkg::xlen-1:0] load_byte_addr;
	logic [rv_pkg::xlen-1:0] mem_addr;
	logic [rv_pkg::xlen-1:0] mem_wdata;
	logic [rv_pkg::xlen-1:0] mem_rdata;
	logic mem_we;

	control_unit control_unit_inst (
		.clk(clk), .reset(reset), .opcode(ir[6:0]), .alu_bcond(alu_bcond),
		.pc_write(pc_write), .pc_write_not_cond(pc_write_not_cond), .iord(iord),
		.mem_read(mem_read), .mem_write(mem_write), .ir_write(ir_write),
		.reg_write(reg_write), .mem_to_reg(mem_to_reg), .pc_source(pc_source),
		.alu_ctrl(alu_ctrl), .alu_src_a(alu_src_a), .alu_src_b(alu_src_b),
		.halted(halted)
	);

	reg_file reg_file_inst (
		.clk(clk), .rs1(ir[19:15]), .rs2(ir[24:20]), .rd(ir[11:7]),
		.wdata(wb_data), .we(reg_write), .rdata1(rdata1), .rdata2(rdata2)
	);

	imm_gen imm_gen_inst (.inst(ir), .imm(imm));

	// ir[30] is imm bit 10 for addi etc; only shifts and r-type read it as funct7
	assign funct7_5 = ir[30] & (ir[5] | (ir[14:12] == 3'b101));

	alu alu_inst (
		.alu_ctrl(alu_ctrl), .funct3(ir[14:12]), .funct7_5(funct7_5),
		.a(alu_a), .b(alu_b), .result(alu_result), .bcond(alu_bcond)
	);

	unified_mem #(.MEM_WORDS(MEM_WORDS)) unified_mem_inst (
		.clk(clk), .addr(mem_addr), .wdata(mem_wdata), .we(mem_we), .rdata(mem_rdata)
	);

	assign alu_a = (alu_src_a == rv_pkg::src_a_reg) ? a_reg : pc;

	always_comb begin
		case (alu_src_b)
			rv_pkg::src_b_reg:  alu_b = b_reg;
			rv_pkg::src_b_four: alu_b = rv_pkg::xlen'(4);
			rv_pkg::src_b_imm:  alu_b = imm;
			default:            alu_b = '0;
		endcase
	end

	assign wb_data = mem_to_reg ? mdr : alu_out;
	assign pc_next = (pc_source == rv_pkg::pc_alu_out) ? alu_out : alu_result;
	assign pc_en = pc_write | (pc_write_not_cond & ~alu_bcond);

	// loader owns the memory port while reset is held
	assign load_byte_addr = {{(rv_pkg::xlen-load_aw-2){1'b0}}, load_addr, 2'b00};
	assign mem_addr = reset ? load_byte_addr : (iord ? alu_out : pc);
	assign mem_wdata = reset ? load_data : b_reg;
	assign mem_we = reset ? load_en : mem_write;

	// controller write strobe, low in IF so nothing shows while loading
	assign store_valid = mem_write;
	assign store_addr = mem_addr;
	assign store_data = mem_wdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (pc_en) begin
			pc <= {pc_next[rv_pkg::xlen-1:1], 1'b0};  // jalr clears bit 0
		end
	end

	always_ff @(posedge clk) begin
		if (ir_write) begin
			ir <= mem_rdata;
		end
		if (mem_read) begin
			mdr <= mem_rdata;
		end
		a_reg <= rdata1;
		b_reg <= rdata2;
		alu_out <= alu_result;
	end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                          clk,
	input  logic [rv_pkg::reg_addr_w-1:0] rs1,
	input  logic [rv_pkg::reg_addr_w-1:0] rs2,
	input  logic [rv_pkg::reg_addr_w-1:0] rd,
	input  logic [rv_pkg::xlen-1:0]       wdata,
	input  logic                          we,
	output logic [rv_pkg::xlen-1:0]       rdata1,
	output logic [rv_pkg::xlen-1:0]       rdata2
);

	logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_addr_w];

	// x0 reads as zero whatever the array holds
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clk) begin
		if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

endmodule

`default_nettype wire

/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;       // data and address width
	localparam int reg_addr_w = 5;  // 32 architectural registers
	localparam int opcode_w = 7;

	// controller states
	// st_halt is the hold entered after ecall and left only by reset
	typedef enum logic [2:0] {
		st_if   = 3'd0,
		st_id   = 3'd1,
		st_ex1  = 3'd2,
		st_ex2  = 3'd3,
		st_mem1 = 3'd4,
		st_wb   = 3'd5,
		st_halt = 3'd6
	} ctrl_state_t;

	// rv32i major opcodes handled by this core
	typedef enum logic [opcode_w-1:0] {
		op_arith     = 7'b0110011,  // r-type
		op_arith_imm = 7'b0010011,
		op_load      = 7'b0000011,
		op_store     = 7'b0100011,
		op_branch    = 7'b1100011,
		op_jal       = 7'b1101111,
		op_jalr      = 7'b1100111,
		op_ecall     = 7'b1110011
	} opcode_t;

	// what the controller asks of the alu
	typedef enum logic [1:0] {
		alu_add  = 2'b00,
		alu_sub  = 2'b01,
		alu_func = 2'b10  // decode funct3/funct7
	} alu_ctrl_t;

	typedef enum logic {
		src_a_pc  = 1'b0,
		src_a_reg = 1'b1
	} alu_src_a_t;

	typedef enum logic [1:0] {
		src_b_reg  = 2'b00,
		src_b_four = 2'b01,
		src_b_imm  = 2'b10
	} alu_src_b_t;

	// next pc from the live alu result or the latched aluout
	typedef enum logic {
		pc_alu_result = 1'b0,
		pc_alu_out    = 1'b1
	} pc_src_t;

endpackage

`default_nettype wire

/* hdl/unified_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module unified_mem #(
	parameter int MEM_WORDS = 256
) (
	input  logic                    clk,
	input  logic [rv_pkg::xlen-1:0] addr,  // byte address
	input  logic [rv_pkg::xlen-1:0] wdata,
	input  logic                    we,
	output logic [rv_pkg::xlen-1:0] rdata
);

	localparam int idx_w = $clog2(MEM_WORDS);

	logic [rv_pkg::xlen-1:0] mem [MEM_WORDS];
	logic [idx_w-1:0] idx;

	assign idx = addr[idx_w+1:2];  // word index
	assign rdata = mem[idx];       // async read, same cycle

	always_ff @(posedge clk) begin
		if (we) begin
			mem[idx] <= wdata;
		end
	end

	// writes beyond the array would alias onto low words
	a_wr_in_range: assert property (@(posedge clk)
		we |-> (addr[rv_pkg::xlen-1:2] < MEM_WORDS))
		else $error("unified_mem: write address %h outside memory", addr);

endmodule

`default_nettype wire

/* test/multicycle_cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module multicycle_cpu_tb;

	localparam int mem_words = 256;
	localparam int n_tests = 3;

	logic clk = 1'b0;
	logic reset;
	logic load_en;
	logic [7:0] load_addr;
	logic [31:0] load_data;
	logic halted;
	logic store_valid;
	logic [31:0] store_addr;
	logic [31:0] store_data;

	// program table, one row per test
	string test_name [n_tests];
	int ld_cnt [n_tests];
	int ld_addr [n_tests][128];  // word address
	logic [31:0] ld_data [n_tests][128];
	int st_cnt [n_tests];
	logic [31:0] st_addr [n_tests][32];
	logic [31:0] st_data [n_tests][32];
	int exp_cycles [n_tests];

	int branch_f3 [6] = '{0, 1, 4, 5, 6, 7};
	integer seed = 28115;
	int cur;      // row being built
	int pc_word;  // next instruction slot
	int errors = 0;
	int checks = 0;
	logic table_ready = 1'b0;

	multicycle_cpu #(.MEM_WORDS(mem_words)) multicycle_cpu_inst (
		.clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .halted(halted), .store_valid(store_valid),
		.store_addr(store_addr), .store_data(store_data)
	);

	always #10 clk = ~clk;

	// rv32i instruction encoders
	function automatic logic [31:0] r_format(input logic alt, input int rs2, input int rs1,
			input logic [2:0] f3, input int rd);
		return {1'b0, alt, 5'd0, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
	endfunction

	function automatic logic [31:0] i_format(input logic [11:0] imm, input int rs1,
			input logic [2:0] f3, input int rd, input logic [6:0] op);
		return {imm, 5'(rs1), f3, 5'(rd), op};
	endfunction

	function automatic logic [31:0] s_format(input logic [11:0] imm, input int rs2,
			input int rs1);
		return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_format(input logic [12:0] imm, input int rs2,
			input int rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] j_format(input logic [20:0] imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
	endfunction

	// reference arithmetic from the isa
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) begin
					r = $signed(a) >>> b[4:0];  // sign fill
				end else begin
					r = a >> b[4:0];
				end
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic new_row(input int row, input string name);
		cur = row;
		pc_word = 0;
		test_name[row] = name;
	endtask

	task automatic put_word(input int byte_addr, input logic [31:0] word);
		ld_addr[cur][ld_cnt[cur]] = byte_addr / 4;
		ld_data[cur][ld_cnt[cur]] = word;
		ld_cnt[cur]++;
	endtask

	// cycles is what the instruction costs on the path actually taken
	task automatic emit(input logic [31:0] word, input int cycles);
		put_word(pc_word * 4, word);
		pc_word++;
		exp_cycles[cur] += cycles;
	endtask

	task automatic expect_store(input int addr, input logic [31:0] data);
		st_addr[cur][st_cnt[cur]] = addr;
		st_data[cur][st_cnt[cur]] = data;
		st_cnt[cur]++;
	endtask

	task automatic arith_program();
		logic [31:0] ra;
		logic [31:0] rb;
		logic [11:0] imm;
		logic [2:0] f3;
		logic alt;
		int slot;
		ra = $random(seed);
		rb = $random(seed);
		slot = 'h380;
		new_row(0, "arithmetic");
		put_word('h300, ra);
		put_word('h304, rb);
		emit(i_format(12'h300, 0, 3'b010, 1, 7'b0000011), 5);  // lw x1
		emit(i_format(12'h304, 0, 3'b010, 2, 7'b0000011), 5);  // lw x2
		// all eight funct3 codes, then sub and sra
		for (int k = 0; k < 10; k++) begin
			f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
			alt = (k >= 8);
			emit(r_format(alt, 2, 1, f3, 3), 4);
			emit(s_format(12'(slot), 3, 0), 4);
			expect_store(slot, alu_model(f3, alt, ra, rb));
			slot += 4;
		end
		for (int k = 0; k < 9; k++) begin
			f3 = (k < 8) ? 3'(k) : 3'd5;
			alt = (k == 8);  // srai
			imm = 12'($random(seed));
			if (f3 == 3'd1 || f3 == 3'd5) begin
				imm = {1'b0, alt, 5'd0, imm[4:0]};  // shamt form
			end
			emit(i_format(imm, 1, f3, 4, 7'b0010011), 4);
			emit(s_format(12'(slot), 4, 0), 4);
			expect_store(slot, alu_model(f3, alt, ra, {{20{imm[11]}}, imm}));
			slot += 4;
		end
		emit(32'h0000_0073, 1);  // ecall, halted shows in its decode cycle
	endtask

	task automatic memory_jump_program();
		logic [31:0] d;
		logic [11:0] imm;
		int link;
		int target;
		d = $random(seed);
		imm = 12'($random(seed));
		new_row(1, "load store jump");
		put_word('h300, d);
		emit(i_format(12'h300, 0, 3'b010, 1, 7'b0000011), 5);
		emit(s_format(12'h340, 1, 0), 4);
		expect_store('h340, d);
		emit(i_format(12'h340, 0, 3'b010, 4, 7'b0000011), 5);  // read it back
		emit(i_format(imm, 4, 3'b000, 4, 7'b0010011), 4);
		emit(s_format(12'h344, 4, 0), 4);
		expect_store('h344, d + {{20{imm[11]}}, imm});
		link = pc_word * 4 + 4;
		emit(j_format(21'd8, 5), 3);      // jal x5, +8
		emit(s_format(12'h348, 4, 0), 0);  // skipped
		emit(s_format(12'h348, 5, 0), 4);
		expect_store('h348, link);
		target = (pc_word + 3) * 4;
		emit(i_format(12'(target - 4), 0, 3'b000, 6, 7'b0010011), 4);
		link = pc_word * 4 + 4;
		emit(i_format(12'd4, 6, 3'b000, 7, 7'b1100111), 3);  // jalr x7, 4(x6)
		emit(s_format(12'h34c, 5, 0), 0);
		emit(s_format(12'h34c, 7, 0), 4);
		expect_store('h34c, link);
		emit(32'h0000_0073, 1);
	endtask

	task automatic branch_program();
		logic [31:0] vals [3];
		logic [2:0] f3;
		logic taken;
		int rs1;
		int rs2;
		int slot;
		vals[0] = '0;
		vals[1] = $random(seed) | 32'h8000_0000;  // negative, large unsigned
		vals[2] = $random(seed) & 32'h7fff_ffff;
		new_row(2, "branches");
		put_word('h300, vals[1]);
		put_word('h304, vals[2]);
		emit(i_format(12'h300, 0, 3'b010, 1, 7'b0000011), 5);
		emit(i_format(12'h304, 0, 3'b010, 2, 7'b0000011), 5);
		emit(i_format(12'd1, 0, 3'b000, 7, 7'b0010011), 4);  // fall-through marker
		emit(i_format(12'd2, 0, 3'b000, 8, 7'b0010011), 4);  // taken marker
		emit(i_format(12'h055, 0, 3'b000, 0, 7'b0010011), 4);  // x0 must ignore this
		emit(s_format(12'h37c, 0, 0), 4);
		expect_store('h37c, 32'd0);
		slot = 'h380;
		for (int c = 0; c < 6; c++) begin
			for (int p = 0; p < 3; p++) begin
				rs1 = (p == 1) ? 2 : 1;
				rs2 = (p == 0) ? 2 : 1;
				f3 = 3'(branch_f3[c]);
				taken = branch_taken(f3, vals[rs1], vals[rs2]);
				emit(b_format(13'd12, rs2, rs1, f3), taken ? 4 : 3);
				emit(s_format(12'(slot), 7, 0), taken ? 0 : 4);
				emit(j_format(21'd8, 0), taken ? 0 : 3);
				emit(s_format(12'(slot), 8, 0), taken ? 4 : 0);
				expect_store(slot, taken ? 32'd2 : 32'd1);
				slot += 4;
			end
		end
		emit(32'h0000_0073, 1);
	endtask

	task automatic run_test(input int row);
		int cycles;
		int seen;
		int errors_before;
		errors_before = errors;
		reset = 1'b1;
		load_en = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		for (int i = 0; i < ld_cnt[row]; i++) begin
			load_en = 1'b1;
			load_addr = 8'(ld_addr[row][i]);
			load_data = ld_data[row][i];
			@(posedge clk);
			#1;
			check("store_valid", 32'(store_valid), 32'd0);  // quiet while loading
		end
		load_en = 1'b0;
		reset = 1'b0;
		cycles = 0;
		seen = 0;
		while (!halted) begin
			@(posedge clk);
			#1;
			cycles++;
			if (store_valid) begin
				if (seen < st_cnt[row]) begin
					check("store_addr", store_addr, st_addr[row][seen]);
					check("store_data", store_data, st_data[row][seen]);
				end
				seen++;
			end
		end
		check("cycles_to_halted", cycles, exp_cycles[row]);
		check("store_count", seen, st_cnt[row]);
		repeat (4) begin
			@(posedge clk);
			#1;
			check("halted", 32'(halted), 32'd1);
			check("store_valid", 32'(store_valid), 32'd0);
		end
		$display("test %0d %s: %0d stores, %0d cycles, %s", row, test_name[row], seen,
			cycles, (errors == errors_before) ? "ok" : "errors");
	endtask

	initial begin
		reset = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		arith_program();
		memory_jump_program();
		branch_program();
		table_ready = 1'b1;
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		$display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// watchdog sized from the table
	initial begin
		int limit;
		limit = 100;
		wait (table_ready);
		for (int t = 0; t < n_tests; t++) begin
			limit += exp_cycles[t] + ld_cnt[t] + 10;
		end
		repeat (limit) @(posedge clk);
		$display("timeout: the run did not finish within %0d clock cycles", limit);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
